/* common/mboxPkg.sv */
// Memory box widths, requester and error enums, diagnostic word union, odd parity function
`default_nettype none

package mboxPkg;

  parameter int WordW = 36;
  parameter int HalfW = 18;
  parameter int AddrW = 22;

  typedef enum logic {
    srcEbox = 1'b0,
    srcChan = 1'b1
  } srcE;

  typedef enum logic [1:0] {
    errNone = 2'd0,
    errNxm  = 2'd1,
    errPar  = 2'd2
  } errCodeE;

  // One diagnostic word, read either as the ERA or as error status
  typedef union packed {
    struct packed {
      logic [WordW-AddrW-3:0] filler;
      srcE                    src;
      logic                   write;
      logic [AddrW-1:0]       era;
    } addrView;
    struct packed {
      logic [WordW-6:0] filler;
      logic             coreBusy;
      logic             parFlag;
      logic             nxmFlag;
      errCodeE          code;
    } statusView;
  } diagWordU;

  // Bit that makes the half plus parity hold an odd number of ones
  function automatic logic oddParity(input logic [HalfW-1:0] half);
    return ~^half;
  endfunction

endpackage

`default_nettype wire

/* rtl/memReqArbiter.sv */
// Channel-priority request arbiter with write parity generation and queue credit counter
`timescale 1ns/10ps
`default_nettype none

module memReqArbiter #(
  parameter int QueueDepth = 4
) (
  input  logic                      clk,
  input  logic                      arstN,
  input  logic                      eboxReq,
  input  logic [mboxPkg::AddrW-1:0] eboxAddr,
  input  logic                      eboxWrite,
  input  logic [mboxPkg::WordW-1:0] eboxWrData,
  input  logic                      chanReq,
  input  logic [mboxPkg::AddrW-1:0] chanAddr,
  input  logic                      chanWrite,
  input  logic [mboxPkg::WordW-1:0] chanWrData,
  input  logic                      creditRet,
  output logic                      eboxRdy,
  output logic                      chanRdy,
  output logic                      push,
  output logic [mboxPkg::AddrW-1:0] pushAddr,
  output logic                      pushWrite,
  output logic [mboxPkg::WordW-1:0] pushData,
  output logic [1:0]                pushPar,
  output mboxPkg::srcE              pushSrc
);

  localparam int CntW = $clog2(QueueDepth + 1);

  logic [CntW-1:0]           credits;
  logic                      haveCredit;
  logic                      chanAcc;
  logic                      eboxAcc;
  logic                      accept;
  logic [mboxPkg::WordW-1:0] winData;

  assign haveCredit = (credits != '0);
  assign chanRdy    = haveCredit;
  // EBOX holds off whenever the channel is asking
  assign eboxRdy    = haveCredit & ~chanReq;

  assign chanAcc = chanReq & chanRdy;
  assign eboxAcc = eboxReq & eboxRdy;
  assign accept  = chanAcc | eboxAcc;
  assign winData = chanAcc ? chanWrData : eboxWrData;

  // Credit is taken on the accepting edge, returned one edge after creditRet
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      credits <= CntW'(QueueDepth);
      push    <= 1'b0;
    end else begin
      push <= accept;
      case ({accept, creditRet})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      pushAddr   <= chanAcc ? chanAddr : eboxAddr;
      pushWrite  <= chanAcc ? chanWrite : eboxWrite;
      pushData   <= winData;
      pushPar[1] <= mboxPkg::oddParity(winData[mboxPkg::WordW-1:mboxPkg::HalfW]);
      pushPar[0] <= mboxPkg::oddParity(winData[mboxPkg::HalfW-1:0]);
      pushSrc    <= chanAcc ? mboxPkg::srcChan : mboxPkg::srcEbox;
    end
  end

  // Returned credits from the queue never outnumber the ones handed out
  creditBound: assert property (@(posedge clk) disable iff (!arstN)
    credits <= CntW'(QueueDepth));

endmodule

`default_nettype wire

/* rtl/reqQueue.sv */
// Show-ahead request FIFO returning one credit per pop
`timescale 1ns/10ps
`default_nettype none

module reqQueue #(
  parameter int QueueDepth = 4
) (
  input  logic                      clk,
  input  logic                      arstN,
  input  logic                      push,
  input  logic [mboxPkg::AddrW-1:0] pushAddr,
  input  logic                      pushWrite,
  input  logic [mboxPkg::WordW-1:0] pushData,
  input  logic [1:0]                pushPar,
  input  mboxPkg::srcE              pushSrc,
  input  logic                      pop,
  output logic                      headValid,
  output logic [mboxPkg::AddrW-1:0] headAddr,
  output logic                      headWrite,
  output logic [mboxPkg::WordW-1:0] headData,
  output logic [1:0]                headPar,
  output mboxPkg::srcE              headSrc,
  output logic                      creditRet,
  output logic                      empty
);

  localparam int PtrW = (QueueDepth > 1) ? $clog2(QueueDepth) : 1;
  localparam int CntW = $clog2(QueueDepth + 1);

  logic [mboxPkg::AddrW-1:0] addrMem  [QueueDepth];
  logic                      writeMem [QueueDepth];
  logic [mboxPkg::WordW-1:0] dataMem  [QueueDepth];
  logic [1:0]                parMem   [QueueDepth];
  mboxPkg::srcE              srcMem   [QueueDepth];

  logic [PtrW-1:0] wrPtr;
  logic [PtrW-1:0] rdPtr;
  logic [CntW-1:0] count;
  logic            full;
  logic            doPop;

  function automatic logic [PtrW-1:0] nextPtr(input logic [PtrW-1:0] ptr);
    if (ptr == PtrW'(QueueDepth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign empty     = (count == '0);
  assign full      = (count == CntW'(QueueDepth));
  assign headValid = ~empty;
  assign doPop     = pop & ~empty;
  assign creditRet = doPop;

  assign headAddr  = addrMem[rdPtr];
  assign headWrite = writeMem[rdPtr];
  assign headData  = dataMem[rdPtr];
  assign headPar   = parMem[rdPtr];
  assign headSrc   = srcMem[rdPtr];

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (push) begin
        wrPtr <= nextPtr(wrPtr);
      end
      if (doPop) begin
        rdPtr <= nextPtr(rdPtr);
      end
      case ({push, doPop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      addrMem[wrPtr]  <= pushAddr;
      writeMem[wrPtr] <= pushWrite;
      dataMem[wrPtr]  <= pushData;
      parMem[wrPtr]   <= pushPar;
      srcMem[wrPtr]   <= pushSrc;
    end
  end

  // Arbiter credits must keep the queue from overflowing
  noOverflow: assert property (@(posedge clk) disable iff (!arstN) push |-> !full);
  noUnderflow: assert property (@(posedge clk) disable iff (!arstN) pop |-> !empty);

endmodule

`default_nettype wire

/* memCycle/memCycleCtl.sv */
// Memory port sequencer with NXM timeout, read parity check and read return
`timescale 1ns/10ps
`default_nettype none

module memCycleCtl #(
  parameter int NxmLimit = 16
) (
  input  logic                      clk,
  input  logic                      arstN,
  input  logic                      headValid,
  input  logic [mboxPkg::AddrW-1:0] headAddr,
  input  logic                      headWrite,
  input  logic [mboxPkg::WordW-1:0] headData,
  input  logic [1:0]                headPar,
  input  mboxPkg::srcE              headSrc,
  input  logic                      empty,
  input  logic                      memAck,
  input  logic [mboxPkg::WordW-1:0] memRdData,
  input  logic [1:0]                memRdPar,
  output logic                      pop,
  output logic                      memReq,
  output logic [mboxPkg::AddrW-1:0] memAddr,
  output logic                      memWrite,
  output logic [mboxPkg::WordW+1:0] memWrData,
  output logic                      rdValid,
  output logic [mboxPkg::WordW-1:0] rdData,
  output mboxPkg::srcE              rdSrc,
  output logic                      coreBusy,
  output logic                      errEvent,
  output mboxPkg::errCodeE          errCode,
  output logic [mboxPkg::AddrW-1:0] errAddr,
  output logic                      errWrite,
  output mboxPkg::srcE              errSrc
);

  localparam int CntW = $clog2(NxmLimit + 1);

  logic [CntW-1:0] nxmCnt;
  logic            timeout;
  logic            ackTaken;
  logic            rdParBad;
  mboxPkg::srcE    cycSrc;

  // memReq doubles as the busy state of the sequencer
  assign pop      = headValid & ~memReq;
  assign ackTaken = memReq & memAck;
  assign timeout  = memReq & ~memAck & (nxmCnt == CntW'(NxmLimit - 1));
  assign coreBusy = ~empty | memReq;

  assign rdParBad =
    (memRdPar[1] != mboxPkg::oddParity(memRdData[mboxPkg::WordW-1:mboxPkg::HalfW])) |
    (memRdPar[0] != mboxPkg::oddParity(memRdData[mboxPkg::HalfW-1:0]));

  // Cycle fields stay put until the next pop
  assign rdSrc    = cycSrc;
  assign errSrc   = cycSrc;
  assign errAddr  = memAddr;
  assign errWrite = memWrite;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      memReq   <= 1'b0;
      nxmCnt   <= '0;
      rdValid  <= 1'b0;
      errEvent <= 1'b0;
    end else begin
      rdValid  <= (ackTaken | timeout) & ~memWrite;
      errEvent <= timeout | (ackTaken & ~memWrite & rdParBad);
      if (pop) begin
        memReq <= 1'b1;
        nxmCnt <= '0;
      end else if (ackTaken | timeout) begin
        memReq <= 1'b0;
      end else if (memReq) begin
        nxmCnt <= nxmCnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      memAddr   <= headAddr;
      memWrite  <= headWrite;
      memWrData <= {headPar, headData};
      cycSrc    <= headSrc;
    end
    // NXM reads come back as zeros
    if (ackTaken) begin
      rdData <= memRdData;
    end else if (timeout) begin
      rdData <= '0;
    end
    if (timeout) begin
      errCode <= mboxPkg::errNxm;
    end else if (ackTaken) begin
      errCode <= mboxPkg::errPar;
    end
  end

  // Request held with a steady address until the memory answers or NXM fires
  reqHeld: assert property (@(posedge clk) disable iff (!arstN)
    memReq && !memAck && !timeout |=> memReq && $stable(memAddr));

endmodule

`default_nettype wire

/* memCycle/errorCapture.sv */
// First-error address register, sticky NXM and parity flags, diagnostic read word
`timescale 1ns/10ps
`default_nettype none

module errorCapture (
  input  logic                      clk,
  input  logic                      arstN,
  input  logic                      errEvent,
  input  mboxPkg::errCodeE          errCode,
  input  logic [mboxPkg::AddrW-1:0] errAddr,
  input  logic                      errWrite,
  input  mboxPkg::srcE              errSrc,
  input  logic                      errClr,
  input  logic                      coreBusy,
  input  logic                      diagSel,
  output logic                      nxmErr,
  output logic                      parErr,
  output logic [mboxPkg::WordW-1:0] diagData
);

  logic                      held;
  logic                      capture;
  logic [mboxPkg::AddrW-1:0] eraAddr;
  logic                      eraWrite;
  mboxPkg::srcE              eraSrc;
  mboxPkg::errCodeE          eraCode;
  mboxPkg::diagWordU         diagWord;

  assign held = nxmErr | parErr;
  // A clear in the same cycle frees the register for the incoming error
  assign capture = errEvent & (~held | errClr);

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      nxmErr <= 1'b0;
      parErr <= 1'b0;
    end else if (capture) begin
      nxmErr <= (errCode == mboxPkg::errNxm);
      parErr <= (errCode == mboxPkg::errPar);
    end else if (errClr) begin
      nxmErr <= 1'b0;
      parErr <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (capture) begin
      eraAddr  <= errAddr;
      eraWrite <= errWrite;
      eraSrc   <= errSrc;
      eraCode  <= errCode;
    end
  end

  always_comb begin
    diagWord = '0;
    if (diagSel) begin
      diagWord.statusView.code     = held ? eraCode : mboxPkg::errNone;
      diagWord.statusView.nxmFlag  = nxmErr;
      diagWord.statusView.parFlag  = parErr;
      diagWord.statusView.coreBusy = coreBusy;
    end else begin
      diagWord.addrView.era   = eraAddr;
      diagWord.addrView.write = eraWrite;
      diagWord.addrView.src   = eraSrc;
    end
    diagData = diagWord;
  end

endmodule

`default_nettype wire

/* rtl/mboxCore.sv */
// Memory box top level with arbiter, request queue, memory cycle control and error capture
`timescale 1ns/10ps
`default_nettype none

module mboxCore #(
  parameter int QueueDepth = 4,
  parameter int NxmLimit   = 16
) (
  input  logic                      clk,
  input  logic                      arstN,
  input  logic                      eboxReq,
  output logic                      eboxRdy,
  input  logic [mboxPkg::AddrW-1:0] eboxAddr,
  input  logic                      eboxWrite,
  input  logic [mboxPkg::WordW-1:0] eboxWrData,
  input  logic                      chanReq,
  output logic                      chanRdy,
  input  logic [mboxPkg::AddrW-1:0] chanAddr,
  input  logic                      chanWrite,
  input  logic [mboxPkg::WordW-1:0] chanWrData,
  output logic                      memReq,
  output logic [mboxPkg::AddrW-1:0] memAddr,
  output logic                      memWrite,
  output logic [mboxPkg::WordW+1:0] memWrData,
  input  logic                      memAck,
  input  logic [mboxPkg::WordW-1:0] memRdData,
  input  logic [1:0]                memRdPar,
  output logic                      rdValid,
  output logic [mboxPkg::WordW-1:0] rdData,
  output mboxPkg::srcE              rdSrc,
  output logic                      coreBusy,
  output logic                      nxmErr,
  output logic                      parErr,
  input  logic                      errClr,
  input  logic                      diagSel,
  output logic [mboxPkg::WordW-1:0] diagData
);

  logic                      push;
  logic [mboxPkg::AddrW-1:0] pushAddr;
  logic                      pushWrite;
  logic [mboxPkg::WordW-1:0] pushData;
  logic [1:0]                pushPar;
  mboxPkg::srcE              pushSrc;
  logic                      creditRet;
  logic                      pop;
  logic                      headValid;
  logic [mboxPkg::AddrW-1:0] headAddr;
  logic                      headWrite;
  logic [mboxPkg::WordW-1:0] headData;
  logic [1:0]                headPar;
  mboxPkg::srcE              headSrc;
  logic                      empty;
  logic                      errEvent;
  mboxPkg::errCodeE          errCode;
  logic [mboxPkg::AddrW-1:0] errAddr;
  logic                      errWrite;
  mboxPkg::srcE              errSrc;

  memReqArbiter #(.QueueDepth(QueueDepth)) i_arbiter (
    .clk, .arstN, .eboxReq, .eboxAddr, .eboxWrite, .eboxWrData,
    .chanReq, .chanAddr, .chanWrite, .chanWrData, .creditRet,
    .eboxRdy, .chanRdy, .push, .pushAddr, .pushWrite, .pushData, .pushPar, .pushSrc
  );

  reqQueue #(.QueueDepth(QueueDepth)) i_queue (
    .clk, .arstN, .push, .pushAddr, .pushWrite, .pushData, .pushPar, .pushSrc, .pop,
    .headValid, .headAddr, .headWrite, .headData, .headPar, .headSrc, .creditRet, .empty
  );

  memCycleCtl #(.NxmLimit(NxmLimit)) i_memCycle (
    .clk, .arstN, .headValid, .headAddr, .headWrite, .headData, .headPar, .headSrc,
    .empty, .memAck, .memRdData, .memRdPar,
    .pop, .memReq, .memAddr, .memWrite, .memWrData, .rdValid, .rdData, .rdSrc,
    .coreBusy, .errEvent, .errCode, .errAddr, .errWrite, .errSrc
  );

  errorCapture i_errCapture (
    .clk, .arstN, .errEvent, .errCode, .errAddr, .errWrite, .errSrc,
    .errClr, .coreBusy, .diagSel, .nxmErr, .parErr, .diagData
  );

endmodule

`default_nettype wire

/* bench/mboxCoreTb.sv */
// Testbench for mboxCore with memory model, pattern-driven stimulus, response checks and watchdog
`timescale 1ns/10ps
`default_nettype none

module mboxCoreTb;

  localparam int QueueDepth = 4;
  localparam int NxmLimit   = 20;
  localparam int MaxPat     = 64;
  localparam logic [21:0] Boundary = 22'h100000;

  logic        clk;
  logic        arstN;
  logic        eboxReq, eboxRdy, eboxWrite, chanReq, chanRdy, chanWrite;
  logic [21:0] eboxAddr, chanAddr, memAddr;
  logic [35:0] eboxWrData, chanWrData, memRdData, rdData, diagData;
  logic        memReq, memWrite, memAck, rdValid, coreBusy, nxmErr, parErr, errClr, diagSel;
  logic [37:0] memWrData;
  logic [1:0]  memRdPar;
  mboxPkg::srcE rdSrc;

  logic        patSrc [MaxPat];
  logic [3:0]  patOp [MaxPat];
  logic [21:0] patAddr [MaxPat];
  logic [35:0] patWData [MaxPat];
  logic        patCorrupt [MaxPat];
  logic [35:0] patExp [MaxPat];
  logic        patNxm [MaxPat];
  logic        patPar [MaxPat];
  int          numPat = 0;

  logic [36:0] expQ [$];
  logic [35:0] refMem [logic [21:0]];
  logic [35:0] modelMem [logic [21:0]];
  logic        stallMem = 1'b0;
  logic        corruptRead = 1'b0;
  logic        held = 1'b0;
  logic [23:0] eraExp;
  logic [1:0]  codeExp;

  mboxCore #(.QueueDepth(QueueDepth), .NxmLimit(NxmLimit)) i_dut (
    .clk, .arstN, .eboxReq, .eboxRdy, .eboxAddr, .eboxWrite, .eboxWrData,
    .chanReq, .chanRdy, .chanAddr, .chanWrite, .chanWrData,
    .memReq, .memAddr, .memWrite, .memWrData, .memAck, .memRdData, .memRdPar,
    .rdValid, .rdData, .rdSrc, .coreBusy, .nxmErr, .parErr, .errClr, .diagSel, .diagData
  );

  // Set when the half alone has an even number of ones
  function automatic logic halfParity(input logic [17:0] half);
    return ($countones(half) % 2) == 0;
  endfunction

  function automatic logic [35:0] refWord(input logic [21:0] a);
    if (a >= Boundary) return '0;
    if (refMem.exists(a)) return refMem[a];
    return 36'hA00000000 | 36'(a);
  endfunction

  task automatic failRun(input string msg);
    $display("%s", msg);
    $display("Simulation FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic checkValue(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("** Error: %s is 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
      failRun("mismatch detected");
    end
  endtask

  task automatic stepCycle();
    @(posedge clk);
    #1;
  endtask

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Memory model, ack after 1 to 4 cycles, silent above the boundary
  initial begin
    int delay;
    memAck = 1'b0;
    memRdData = '0;
    memRdPar = '0;
    forever begin
      stepCycle();
      memAck = 1'b0;
      if (arstN && memReq && !stallMem && memAddr < Boundary) begin
        delay = $urandom_range(4, 1);
        for (int i = 1; i < delay; i++) stepCycle();
        memAck = 1'b1;
        if (memWrite) begin
          checkValue("memWrData par hi", memWrData[37], halfParity(memWrData[35:18]));
          checkValue("memWrData par lo", memWrData[36], halfParity(memWrData[17:0]));
          modelMem[memAddr] = memWrData[35:0];
        end else begin
          memRdData = modelMem.exists(memAddr) ? modelMem[memAddr] :
                      (36'hA00000000 | 36'(memAddr));
          memRdPar = {halfParity(memRdData[35:18]), halfParity(memRdData[17:0])};
          if (corruptRead) memRdPar[0] = ~memRdPar[0];
          corruptRead = 1'b0;
        end
      end
    end
  end

  // Read responses checked in acceptance order
  always @(negedge clk) begin
    logic [36:0] e;
    if (arstN && rdValid) begin
      if (expQ.size() == 0) failRun("read response arrived with no read outstanding");
      e = expQ.pop_front();
      checkValue("rdData", rdData, e[35:0]);
      checkValue("rdSrc", rdSrc, e[36]);
    end
  end

  initial begin
    wait (arstN === 1'b1);
    repeat (numPat * (NxmLimit + 10) + 50) @(posedge clk);
    failRun("watchdog expired before all patterns finished");
  end

  task automatic loadPatterns();
    int fd;
    string line;
    logic [63:0] f [8];
    fd = $fopen("bench/mboxPatterns.txt", "r");
    if (fd == 0) failRun("cannot open bench/mboxPatterns.txt");
    while ($fgets(line, fd) > 0) begin
      if (line.len() > 1 && line.substr(0, 0) != "#" &&
          $sscanf(line, "%h %h %h %h %h %h %h %h", f[0], f[1], f[2], f[3], f[4], f[5],
                  f[6], f[7]) == 8) begin
        patSrc[numPat] = f[0][0];
        patOp[numPat] = f[1][3:0];
        patAddr[numPat] = f[2][21:0];
        patWData[numPat] = f[3][35:0];
        patCorrupt[numPat] = f[4][0];
        patExp[numPat] = f[5][35:0];
        patNxm[numPat] = f[6][0];
        patPar[numPat] = f[7][0];
        numPat++;
      end
    end
    $fclose(fd);
  endtask

  task automatic issueSingle(input int idx);
    logic ok;
    corruptRead = patCorrupt[idx];
    if (patSrc[idx]) begin
      chanReq = 1'b1;
      chanAddr = patAddr[idx];
      chanWrite = patOp[idx][0];
      chanWrData = patWData[idx];
    end else begin
      eboxReq = 1'b1;
      eboxAddr = patAddr[idx];
      eboxWrite = patOp[idx][0];
      eboxWrData = patWData[idx];
    end
    do begin
      @(negedge clk);
      ok = patSrc[idx] ? chanRdy : eboxRdy;
      if (!ok) stepCycle();
    end while (!ok);
    if (patOp[idx][0]) begin
      if (patAddr[idx] < Boundary) refMem[patAddr[idx]] = patWData[idx];
    end else begin
      expQ.push_back({patSrc[idx], patExp[idx]});
    end
    stepCycle();
    chanReq = 1'b0;
    eboxReq = 1'b0;
  endtask

  task automatic issuePair(input int idx);
    chanReq = 1'b1;
    chanAddr = patAddr[idx];
    chanWrite = 1'b0;
    eboxReq = 1'b1;
    eboxAddr = patWData[idx][21:0];
    eboxWrite = 1'b0;
    @(negedge clk);
    while (!chanRdy) begin
      stepCycle();
      @(negedge clk);
    end
    checkValue("eboxRdy", eboxRdy, 1'b0);
    expQ.push_back({1'b1, patExp[idx]});
    stepCycle();
    chanReq = 1'b0;
    @(negedge clk);
    while (!eboxRdy) begin
      stepCycle();
      @(negedge clk);
    end
    expQ.push_back({1'b0, refWord(eboxAddr)});
    stepCycle();
    eboxReq = 1'b0;
  endtask

  task automatic runStall(input int idx);
    int cnt;
    int idle;
    logic [21:0] a;
    cnt = 0;
    idle = 0;
    a = patAddr[idx];
    stallMem = 1'b1;
    eboxReq = 1'b1;
    eboxWrite = 1'b0;
    eboxAddr = a;
    while (idle < 4) begin
      @(negedge clk);
      if (eboxRdy) begin
        expQ.push_back({1'b0, refWord(a)});
        cnt++;
        idle = 0;
        a++;
      end else begin
        idle++;
      end
      stepCycle();
      eboxAddr = a;
    end
    checkValue("acceptedCount", cnt, QueueDepth + 1);
    checkValue("chanRdy", chanRdy, 1'b0);
    checkValue("eboxRdy", eboxRdy, 1'b0);
    checkValue("coreBusy", coreBusy, 1'b1);
    eboxReq = 1'b0;
    stallMem = 1'b0;
  endtask

  task automatic drainAll();
    repeat (2) @(posedge clk);
    do @(negedge clk); while (expQ.size() != 0 || coreBusy);
    repeat (2) @(posedge clk);
    #1;
  endtask

  task automatic checkErrors(input int idx);
    if ((patNxm[idx] || patPar[idx]) && !held) begin
      held = 1'b1;
      eraExp = {patSrc[idx], patOp[idx][0], patAddr[idx]};
      codeExp = patNxm[idx] ? 2'd1 : 2'd2;
    end
    diagSel = 1'b0;
    @(negedge clk);
    checkValue("nxmErr", nxmErr, patNxm[idx]);
    checkValue("parErr", parErr, patPar[idx]);
    if (held) checkValue("diagData addr view", diagData[23:0], eraExp);
    stepCycle();
    diagSel = 1'b1;
    @(negedge clk);
    checkValue("diagData status view", diagData[4:0],
               {1'b0, patPar[idx], patNxm[idx], held ? codeExp : 2'd0});
    stepCycle();
    diagSel = 1'b0;
  endtask

  initial begin
    void'($urandom(32'hb60f));
    arstN = 1'b0;
    {eboxReq, eboxWrite, chanReq, chanWrite, errClr, diagSel} = '0;
    {eboxAddr, chanAddr} = '0;
    {eboxWrData, chanWrData} = '0;
    loadPatterns();
    repeat (3) @(posedge clk);
    #1;
    arstN = 1'b1;
    @(negedge clk);
    checkValue("eboxRdy", eboxRdy, 1'b1);
    checkValue("chanRdy", chanRdy, 1'b1);
    checkValue("memReq", memReq, 1'b0);
    stepCycle();
    for (int i = 0; i < numPat; i++) begin
      repeat ($urandom_range(3, 0)) stepCycle();
      case (patOp[i])
        4'd0, 4'd1: issueSingle(i);
        4'd2: issuePair(i);
        4'd3: begin
          errClr = 1'b1;
          stepCycle();
          errClr = 1'b0;
          held = 1'b0;
        end
        default: runStall(i);
      endcase
      drainAll();
      checkErrors(i);
    end
    if (expQ.size() != 0) begin
      failRun("reads still outstanding at the end of the run");
    end else begin
      $display("Simulation PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* bench/mboxPatterns.txt */
# src(0 ebox 1 chan) op(0 rd 1 wr 2 pair 3 clear 4 stall) addr wdata corrupt expData nxm par
# pair lines read addr on the channel and the wdata column as EBOX address
0 0 000100 000000000 0 A00000100 0 0
1 0 000200 000000000 0 A00000200 0 0
0 1 000300 123456789 0 000000000 0 0
1 0 000300 000000000 0 123456789 0 0
1 1 000310 FEDCBA987 0 000000000 0 0
0 0 000310 000000000 0 FEDCBA987 0 0
1 2 000400 000000401 0 A00000400 0 0
1 2 000500 000000300 0 A00000500 0 0
0 0 200000 000000000 0 000000000 1 0
1 0 000600 000000000 1 A00000600 1 0
0 0 000610 000000000 0 A00000610 1 0
0 3 000000 000000000 0 000000000 0 0
1 0 000700 000000000 1 A00000700 0 1
0 0 250000 000000000 0 000000000 0 1
0 3 000000 000000000 0 000000000 0 0
1 1 300000 ABCDEF012 0 000000000 1 0
0 3 000000 000000000 0 000000000 0 0
0 4 000800 000000000 0 000000000 0 0
0 0 000800 000000000 0 A00000800 0 0
1 0 000100 000000000 0 A00000100 0 0

/* flist.f */
common/mboxPkg.sv
rtl/memReqArbiter.sv
rtl/reqQueue.sv
memCycle/memCycleCtl.sv
memCycle/errorCapture.sv
rtl/mboxCore.sv
bench/mboxCoreTb.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= mboxCoreTb
FLIST     ?= flist.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJDIR)

run: compile
	-./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
